/* hw/cpu_pkg.sv */
// shared word and register index types
// opcode, function and ALU operation encodings
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // HALT is the all-ones opcode
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        BEQ   = 6'h04,
        ADDIU = 6'h09,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcode_t;

    typedef enum logic [5:0] {
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

endpackage

`default_nettype wire

/* hw/mem_arbiter.sv */
// arbiter between instruction fetch and data access on one bus
// data wins a new request; an access in flight keeps its owner
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cpu_pkg::*; (
    input  wire   CLK,
    input  wire   nRST,
    input  wire   imem_ren_i,
    input  word_t imem_addr_i,
    input  wire   dmem_ren_i,
    input  wire   dmem_wen_i,
    input  word_t dmem_addr_i,
    input  word_t dmem_store_i,
    input  word_t mem_load_i,
    input  wire   mem_ready_i,
    output word_t imem_load_o,
    output logic  ihit_o,
    output word_t dmem_load_o,
    output logic  dhit_o,
    output logic  mem_ren_o,
    output logic  mem_wen_o,
    output word_t mem_addr_o,
    output word_t mem_store_o
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSTR,
        OWN_DATA
    } owner_t;

    owner_t owner, owner_next;
    logic   dreq;
    logic   sel_data;
    logic   busy;

    assign dreq     = dmem_ren_i | dmem_wen_i;
    assign sel_data = (owner == OWN_DATA) || (owner == OWN_NONE && dreq);
    assign busy     = sel_data ? dreq : imem_ren_i;

    assign mem_ren_o   = sel_data ? dmem_ren_i : imem_ren_i;
    assign mem_wen_o   = sel_data & dmem_wen_i;
    assign mem_addr_o  = sel_data ? dmem_addr_i : imem_addr_i;
    assign mem_store_o = dmem_store_i;

    assign ihit_o      = ~sel_data & imem_ren_i & mem_ready_i;
    assign dhit_o      = sel_data & dreq & mem_ready_i;
    assign imem_load_o = mem_load_i;
    assign dmem_load_o = mem_load_i;

    // hold the grant until the access completes
    always_comb begin
        owner_next = OWN_NONE;
        if (busy && !mem_ready_i) begin
            owner_next = sel_data ? OWN_DATA : OWN_INSTR;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner <= OWN_NONE;
        end else begin
            owner <= owner_next;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
// program counter and IF/ID latch
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter word_t PC_INIT = '0
) (
    input  wire   CLK,
    input  wire   nRST,
    input  wire   ihit_i,
    input  word_t imem_load_i,
    input  wire   stall_mem_i,
    input  wire   hazard_stall_i,
    input  wire   branch_taken_i,
    input  word_t branch_target_i,
    input  wire   halt_i,
    output logic  imem_ren_o,
    output word_t imem_addr_o,
    output word_t if_instr_o,
    output word_t if_pc_plus4_o
);

    word_t pc;
    word_t pc_plus4;
    logic  started;
    logic  advance;
    logic  load_fetch;

    assign advance     = ihit_i & ~stall_mem_i;
    assign load_fetch  = advance & ~branch_taken_i & ~hazard_stall_i;
    assign pc_plus4    = pc + 32'd4;
    assign imem_ren_o  = started & ~halt_i;
    assign imem_addr_o = pc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc         <= PC_INIT;
            started    <= 1'b0;
            if_instr_o <= '0;
        end else begin
            started <= 1'b1;
            if (advance && branch_taken_i) begin
                pc         <= branch_target_i;
                if_instr_o <= '0;
            end else if (load_fetch) begin
                pc         <= pc_plus4;
                if_instr_o <= imem_load_i;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load_fetch) begin
            if_pc_plus4_o <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// instruction decode, register file and RAW stall detection
// ID/EX latch
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire       CLK,
    input  wire       nRST,
    input  word_t     if_instr_i,
    input  word_t     if_pc_plus4_i,
    input  wire       ihit_i,
    input  wire       stall_mem_i,
    input  wire       branch_taken_i,
    input  wire       wb_wen_i,
    input  reg_addr_t wb_sel_i,
    input  word_t     wb_data_i,
    output logic      hazard_stall_o,
    output alu_op_t   id_alu_op_o,
    output word_t     id_rdat1_o,
    output word_t     id_rdat2_o,
    output word_t     id_imm_o,
    output word_t     id_pc_plus4_o,
    output reg_addr_t id_dest_o,
    output logic      id_regwen_o,
    output logic      id_alusrc_o,
    output logic      id_load_o,
    output logic      id_store_o,
    output logic      id_beq_o,
    output logic      id_halt_o
);

    word_t     regs [32];
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs, rt, rd;
    word_t     imm, rdat1, rdat2;

    alu_op_t   alu_op;
    reg_addr_t dest;
    logic      regwen, alusrc, load, store, beq, halt;
    logic      use_rs, use_rt;

    // destination of the instruction now in EX/MEM
    reg_addr_t exm_dest;
    logic      exm_wen;
    logic      advance;
    logic      flush;

    assign opcode = opcode_t'(if_instr_i[31:26]);
    assign funct  = funct_t'(if_instr_i[5:0]);
    assign rs     = if_instr_i[25:21];
    assign rt     = if_instr_i[20:16];
    assign rd     = if_instr_i[15:11];
    assign imm    = {{16{if_instr_i[15]}}, if_instr_i[15:0]};

    always_comb begin
        alu_op = ALU_ADD;
        dest   = '0;
        regwen = 1'b0;
        alusrc = 1'b0;
        load   = 1'b0;
        store  = 1'b0;
        beq    = 1'b0;
        halt   = 1'b0;
        use_rs = 1'b1;
        use_rt = 1'b0;
        case (opcode)
            RTYPE: begin
                regwen = 1'b1;
                dest   = rd;
                use_rt = 1'b1;
                case (funct)
                    ADDU:    alu_op = ALU_ADD;
                    SUBU:    alu_op = ALU_SUB;
                    AND:     alu_op = ALU_AND;
                    OR:      alu_op = ALU_OR;
                    SLT:     alu_op = ALU_SLT;
                    default: begin
                        regwen = 1'b0;
                        dest   = '0;
                    end
                endcase
            end
            ADDIU, LW: begin
                regwen = 1'b1;
                alusrc = 1'b1;
                load   = (opcode == LW);
                dest   = rt;
            end
            SW: begin
                alusrc = 1'b1;
                store  = 1'b1;
                use_rt = 1'b1;
            end
            BEQ: begin
                alu_op = ALU_SUB;
                beq    = 1'b1;
                use_rt = 1'b1;
            end
            HALT: begin
                halt   = 1'b1;
                use_rs = 1'b0;
            end
            default: use_rs = 1'b0;
        endcase
    end

    function automatic logic raw(reg_addr_t src, reg_addr_t dst, logic wen);
        return wen && dst != '0 && src == dst;
    endfunction

    assign hazard_stall_o =
        (use_rs && (raw(rs, id_dest_o, id_regwen_o) || raw(rs, exm_dest, exm_wen) ||
                    raw(rs, wb_sel_i, wb_wen_i))) ||
        (use_rt && (raw(rt, id_dest_o, id_regwen_o) || raw(rt, exm_dest, exm_wen) ||
                    raw(rt, wb_sel_i, wb_wen_i)));

    // register 0 reads zero and a same-cycle write is bypassed
    assign rdat1 = (rs == '0) ? '0 : (wb_wen_i && wb_sel_i == rs) ? wb_data_i : regs[rs];
    assign rdat2 = (rt == '0) ? '0 : (wb_wen_i && wb_sel_i == rt) ? wb_data_i : regs[rt];

    always_ff @(posedge CLK) begin
        if (wb_wen_i && wb_sel_i != '0) begin
            regs[wb_sel_i] <= wb_data_i;
        end
    end

    assign advance = ihit_i & ~stall_mem_i;
    assign flush   = branch_taken_i | hazard_stall_o;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            id_regwen_o <= 1'b0;
            id_load_o   <= 1'b0;
            id_store_o  <= 1'b0;
            id_beq_o    <= 1'b0;
            id_halt_o   <= 1'b0;
            exm_wen     <= 1'b0;
            exm_dest    <= '0;
        end else if (advance) begin
            id_regwen_o <= regwen & ~flush;
            id_load_o   <= load & ~flush;
            id_store_o  <= store & ~flush;
            id_beq_o    <= beq & ~flush;
            id_halt_o   <= halt & ~flush;
            // ID/EX moves on unless a taken branch squashes it
            exm_wen     <= id_regwen_o & ~branch_taken_i;
            exm_dest    <= id_dest_o;
        end
    end

    always_ff @(posedge CLK) begin
        if (advance) begin
            id_alu_op_o   <= alu_op;
            id_rdat1_o    <= rdat1;
            id_rdat2_o    <= rdat2;
            id_imm_o      <= imm;
            id_pc_plus4_o <= if_pc_plus4_i;
            id_dest_o     <= dest;
            id_alusrc_o   <= alusrc;
        end
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
// ALU, branch target and compare
// EX/MEM latch and branch resolution
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  wire       CLK,
    input  wire       nRST,
    input  wire       ihit_i,
    input  wire       stall_mem_i,
    input  alu_op_t   id_alu_op_i,
    input  word_t     id_rdat1_i,
    input  word_t     id_rdat2_i,
    input  word_t     id_imm_i,
    input  word_t     id_pc_plus4_i,
    input  reg_addr_t id_dest_i,
    input  wire       id_regwen_i,
    input  wire       id_alusrc_i,
    input  wire       id_load_i,
    input  wire       id_store_i,
    input  wire       id_beq_i,
    input  wire       id_halt_i,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output word_t     ex_result_o,
    output word_t     ex_store_data_o,
    output reg_addr_t ex_dest_o,
    output logic      ex_regwen_o,
    output logic      ex_load_o,
    output logic      ex_store_o,
    output logic      ex_halt_o
);

    word_t op_b;
    word_t result;
    word_t target;
    logic  advance;
    logic  squash;
    logic  ex_zero;
    logic  ex_beq;

    assign op_b   = id_alusrc_i ? id_imm_i : id_rdat2_i;
    assign target = id_pc_plus4_i + {id_imm_i[29:0], 2'b00};

    always_comb begin
        case (id_alu_op_i)
            ALU_SUB: result = id_rdat1_i - op_b;
            ALU_AND: result = id_rdat1_i & op_b;
            ALU_OR:  result = id_rdat1_i | op_b;
            ALU_SLT: result = {31'b0, $signed(id_rdat1_i) < $signed(op_b)};
            default: result = id_rdat1_i + op_b;
        endcase
    end

    assign branch_taken_o = ex_beq & ex_zero;
    assign advance        = ihit_i & ~stall_mem_i;
    // the instruction behind a taken branch never reaches memory
    assign squash         = branch_taken_o;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_regwen_o <= 1'b0;
            ex_load_o   <= 1'b0;
            ex_store_o  <= 1'b0;
            ex_halt_o   <= 1'b0;
            ex_beq      <= 1'b0;
        end else if (advance) begin
            ex_regwen_o <= id_regwen_i & ~squash;
            ex_load_o   <= id_load_i & ~squash;
            ex_store_o  <= id_store_i & ~squash;
            ex_halt_o   <= id_halt_i & ~squash;
            ex_beq      <= id_beq_i & ~squash;
        end
    end

    always_ff @(posedge CLK) begin
        if (advance) begin
            ex_result_o     <= result;
            ex_store_data_o <= id_rdat2_i;
            ex_dest_o       <= id_dest_i;
            ex_zero         <= (result == '0);
            branch_target_o <= target;
        end
    end

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
// data access control and sticky halt
// MEM/WB latch and writeback select
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
    input  wire       CLK,
    input  wire       nRST,
    input  wire       ihit_i,
    input  wire       dhit_i,
    input  word_t     dmem_load_i,
    input  word_t     ex_result_i,
    input  word_t     ex_store_data_i,
    input  reg_addr_t ex_dest_i,
    input  wire       ex_regwen_i,
    input  wire       ex_load_i,
    input  wire       ex_store_i,
    input  wire       ex_halt_i,
    output logic      dmem_ren_o,
    output logic      dmem_wen_o,
    output word_t     dmem_addr_o,
    output word_t     dmem_store_o,
    output logic      stall_mem_o,
    output logic      halt_o,
    output logic      wb_wen_o,
    output reg_addr_t wb_sel_o,
    output word_t     wb_data_o
);

    logic  done;
    logic  advance;
    word_t load_q;

    // strobes drop once the access has its dhit
    assign dmem_ren_o   = ex_load_i & ~done;
    assign dmem_wen_o   = ex_store_i & ~done;
    assign dmem_addr_o  = ex_result_i;
    assign dmem_store_o = ex_store_data_i;
    assign stall_mem_o  = (ex_load_i | ex_store_i) & ~done;
    assign advance      = ihit_i & ~stall_mem_o;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            done     <= 1'b0;
            halt_o   <= 1'b0;
            wb_wen_o <= 1'b0;
        end else begin
            halt_o <= halt_o | ex_halt_i;
            if (advance) begin
                done     <= 1'b0;
                wb_wen_o <= ex_regwen_i;
            end else if (dhit_i) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (dhit_i) begin
            load_q <= dmem_load_i;
        end
        if (advance) begin
            wb_sel_o  <= ex_dest_i;
            wb_data_o <= ex_load_i ? load_q : ex_result_i;
        end
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
// processor top level
// five pipeline stages sharing one memory bus through an arbiter
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t PC_INIT = '0
) (
    input  wire   CLK,
    input  wire   nRST,
    input  word_t mem_load_i,
    input  wire   mem_ready_i,
    output logic  mem_ren_o,
    output logic  mem_wen_o,
    output word_t mem_addr_o,
    output word_t mem_store_o,
    output logic  halt_o
);

    logic      imem_ren, ihit, dmem_ren, dmem_wen, dhit;
    word_t     imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;
    logic      stall_mem, hazard_stall, branch_taken;
    word_t     branch_target;
    word_t     if_instr, if_pc_plus4;
    logic      wb_wen;
    reg_addr_t wb_sel;
    word_t     wb_data;

    // ID/EX fields
    alu_op_t   id_alu_op;
    word_t     id_rdat1, id_rdat2, id_imm, id_pc_plus4;
    reg_addr_t id_dest;
    logic      id_regwen, id_alusrc, id_load, id_store, id_beq, id_halt;

    // EX/MEM fields
    word_t     ex_result, ex_store_data;
    reg_addr_t ex_dest;
    logic      ex_regwen, ex_load, ex_store, ex_halt;

    mem_arbiter u_mem_arbiter (
        .CLK(CLK), .nRST(nRST),
        .imem_ren_i(imem_ren), .imem_addr_i(imem_addr),
        .dmem_ren_i(dmem_ren), .dmem_wen_i(dmem_wen),
        .dmem_addr_i(dmem_addr), .dmem_store_i(dmem_store),
        .mem_load_i(mem_load_i), .mem_ready_i(mem_ready_i),
        .imem_load_o(imem_load), .ihit_o(ihit),
        .dmem_load_o(dmem_load), .dhit_o(dhit),
        .mem_ren_o(mem_ren_o), .mem_wen_o(mem_wen_o),
        .mem_addr_o(mem_addr_o), .mem_store_o(mem_store_o)
    );

    fetch_stage #(.PC_INIT(PC_INIT)) u_fetch_stage (
        .CLK(CLK), .nRST(nRST),
        .ihit_i(ihit), .imem_load_i(imem_load),
        .stall_mem_i(stall_mem), .hazard_stall_i(hazard_stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .halt_i(halt_o),
        .imem_ren_o(imem_ren), .imem_addr_o(imem_addr),
        .if_instr_o(if_instr), .if_pc_plus4_o(if_pc_plus4)
    );

    decode_stage u_decode_stage (
        .CLK(CLK), .nRST(nRST),
        .if_instr_i(if_instr), .if_pc_plus4_i(if_pc_plus4),
        .ihit_i(ihit), .stall_mem_i(stall_mem), .branch_taken_i(branch_taken),
        .wb_wen_i(wb_wen), .wb_sel_i(wb_sel), .wb_data_i(wb_data),
        .hazard_stall_o(hazard_stall),
        .id_alu_op_o(id_alu_op), .id_rdat1_o(id_rdat1), .id_rdat2_o(id_rdat2),
        .id_imm_o(id_imm), .id_pc_plus4_o(id_pc_plus4), .id_dest_o(id_dest),
        .id_regwen_o(id_regwen), .id_alusrc_o(id_alusrc), .id_load_o(id_load),
        .id_store_o(id_store), .id_beq_o(id_beq), .id_halt_o(id_halt)
    );

    execute_stage u_execute_stage (
        .CLK(CLK), .nRST(nRST),
        .ihit_i(ihit), .stall_mem_i(stall_mem),
        .id_alu_op_i(id_alu_op), .id_rdat1_i(id_rdat1), .id_rdat2_i(id_rdat2),
        .id_imm_i(id_imm), .id_pc_plus4_i(id_pc_plus4), .id_dest_i(id_dest),
        .id_regwen_i(id_regwen), .id_alusrc_i(id_alusrc), .id_load_i(id_load),
        .id_store_i(id_store), .id_beq_i(id_beq), .id_halt_i(id_halt),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .ex_result_o(ex_result), .ex_store_data_o(ex_store_data), .ex_dest_o(ex_dest),
        .ex_regwen_o(ex_regwen), .ex_load_o(ex_load), .ex_store_o(ex_store),
        .ex_halt_o(ex_halt)
    );

    memory_stage u_memory_stage (
        .CLK(CLK), .nRST(nRST),
        .ihit_i(ihit), .dhit_i(dhit), .dmem_load_i(dmem_load),
        .ex_result_i(ex_result), .ex_store_data_i(ex_store_data), .ex_dest_i(ex_dest),
        .ex_regwen_i(ex_regwen), .ex_load_i(ex_load), .ex_store_i(ex_store),
        .ex_halt_i(ex_halt),
        .dmem_ren_o(dmem_ren), .dmem_wen_o(dmem_wen),
        .dmem_addr_o(dmem_addr), .dmem_store_o(dmem_store),
        .stall_mem_o(stall_mem), .halt_o(halt_o),
        .wb_wen_o(wb_wen), .wb_sel_o(wb_sel), .wb_data_o(wb_data)
    );

endmodule

`default_nettype wire

/* test/cpu_tb.sv */
// testbench for the pipelined processor
// memory model with random ready latency, trace reader, store and bus checks, timeout
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int MEM_WORDS = 256;

    logic        CLK = 1'b0;
    logic        nRST;
    logic [31:0] mem_load_i;
    logic        mem_ready_i;
    logic        mem_ren_o;
    logic        mem_wen_o;
    logic        halt_o;
    logic [31:0] mem_addr_o;
    logic [31:0] mem_store_o;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr_state;
    logic [31:0] last_addr;
    logic [31:0] last_store;
    logic        last_ren;
    logic        last_wen;
    logic        waiting;
    logic        halt_seen;
    logic        trace_loaded;
    int          wait_left;
    int          prog_words;
    int          cycle_limit;
    int          cycle_count;
    int          mismatches;
    int          other_errors;
    int          stores_seen;

    cpu_top #(.PC_INIT(32'h0)) u_cpu_top (
        .CLK(CLK), .nRST(nRST),
        .mem_load_i(mem_load_i), .mem_ready_i(mem_ready_i),
        .mem_ren_o(mem_ren_o), .mem_wen_o(mem_wen_o),
        .mem_addr_o(mem_addr_o), .mem_store_o(mem_store_o),
        .halt_o(halt_o)
    );

    initial begin
        forever #4 CLK = ~CLK;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            mismatches++;
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_delay(output int d);
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i]    = lfsr_state[0];
        end
        d = {30'b0, bits};
    endtask

    task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
        if (exp_addr.size() == 0) begin
            $display("unexpected store of %h to address %h after the last expected store",
                     data, addr);
            other_errors++;
        end else begin
            check_value(addr, exp_addr.pop_front(), "store address");
            check_value(data, exp_data.pop_front(), "store data");
        end
        stores_seen++;
    endtask

    task automatic load_trace;
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("test/cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/cpu_trace.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = line[0];
                if (kind == "P" || kind == "S") begin
                    n = $sscanf(line.substr(1, line.len() - 1), " %h %h", addr, data);
                    if (n != 2) begin
                        $display("malformed trace line: %s", line);
                        other_errors++;
                    end else if (kind == "P") begin
                        mem[addr[9:2]] = data;
                        prog_words++;
                    end else begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finish_run;
        $display("mismatches: %0d, other errors: %0d, stores seen: %0d",
                 mismatches, other_errors, stores_seen);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // memory model with one access per strobe and ready after 0 to 3 cycles
    always @(negedge CLK) begin
        logic       strobe;
        logic [7:0] idx;
        strobe = mem_ren_o | mem_wen_o;
        idx    = mem_addr_o[9:2];
        check_value({31'b0, mem_ren_o & mem_wen_o}, 32'd0, "read and write strobe together");
        halt_seen = halt_seen | halt_o;
        if (halt_seen) begin
            check_value({31'b0, halt_o}, 32'd1, "halt_o held high");
            check_value({31'b0, strobe}, 32'd0, "bus strobe after halt");
        end
        if (waiting && strobe) begin
            check_value({31'b0, mem_ren_o}, {31'b0, last_ren}, "read strobe held");
            check_value({31'b0, mem_wen_o}, {31'b0, last_wen}, "write strobe held");
            check_value(mem_addr_o, last_addr, "address held while waiting");
            if (mem_wen_o) begin
                check_value(mem_store_o, last_store, "store data held while waiting");
            end
        end
        if (!strobe) begin
            mem_ready_i = 1'b0;
            waiting     = 1'b0;
        end else begin
            if (!waiting) begin
                draw_delay(wait_left);
            end
            if (wait_left == 0) begin
                mem_ready_i = 1'b1;
                waiting     = 1'b0;
                mem_load_i  = mem[idx];
                if (mem_wen_o) begin
                    mem[idx] = mem_store_o;
                    record_store(mem_addr_o, mem_store_o);
                end
            end else begin
                mem_ready_i = 1'b0;
                waiting     = 1'b1;
                wait_left--;
            end
        end
        last_ren   = mem_ren_o;
        last_wen   = mem_wen_o;
        last_addr  = mem_addr_o;
        last_store = mem_store_o;
    end

    initial begin : watchdog
        wait (trace_loaded);
        cycle_limit = 60 * prog_words + 200;
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout, halt_o did not rise within %0d cycles", cycle_limit);
        other_errors++;
        finish_run();
    end

    initial begin
        nRST         = 1'b0;
        mem_load_i   = '0;
        mem_ready_i  = 1'b0;
        waiting      = 1'b0;
        halt_seen    = 1'b0;
        wait_left    = 0;
        lfsr_state   = 32'h62f03bc9;
        mismatches   = 0;
        other_errors = 0;
        stores_seen  = 0;
        prog_words   = 0;
        trace_loaded = 1'b0;
        // unwritten words hold their own index and decode as harmless R-type
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i;
        end
        load_trace();
        trace_loaded = 1'b1;

        repeat (5) @(negedge CLK);
        nRST = 1'b1;

        while (!halt_o) begin
            @(negedge CLK);
        end
        // bus must stay quiet once halted
        repeat (20) @(negedge CLK);
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared on the bus", exp_addr.size());
            other_errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* test/cpu_trace.txt */
# P <addr> <word>  memory image loaded before reset, program then data
# S <addr> <data>  expected stores in program order
P 00000000 24010035  addiu $1,$0,0x35
P 00000004 2402fffa  addiu $2,$0,-6
P 00000008 00221821  addu  $3,$1,$2
P 0000000c 00412023  subu  $4,$2,$1
P 00000010 00222824  and   $5,$1,$2
P 00000014 00223025  or    $6,$1,$2
P 00000018 0041382a  slt   $7,$2,$1
P 0000001c 00210021  addu  $0,$1,$1
P 00000020 ac030100  sw    $3,0x100($0)
P 00000024 ac040104  sw    $4,0x104($0)
P 00000028 ac050108  sw    $5,0x108($0)
P 0000002c ac06010c  sw    $6,0x10c($0)
P 00000030 ac070110  sw    $7,0x110($0)
P 00000034 ac000114  sw    $0,0x114($0)
P 00000038 8c080200  lw    $8,0x200($0)
P 0000003c 01014821  addu  $9,$8,$1
P 00000040 2529ffff  addiu $9,$9,-1
P 00000044 ac090118  sw    $9,0x118($0)
P 00000048 10220001  beq   $1,$2,+1  not taken
P 0000004c ac01011c  sw    $1,0x11c($0)
P 00000050 ac020120  sw    $2,0x120($0)
P 00000054 10630002  beq   $3,$3,+2  taken
P 00000058 ac010124  sw    $1,0x124($0)  skipped
P 0000005c ac010128  sw    $1,0x128($0)  skipped
P 00000060 0022582a  slt   $11,$1,$2
P 00000064 11600001  beq   $11,$0,+1  taken
P 00000068 ac05012c  sw    $5,0x12c($0)  skipped
P 0000006c ac050130  sw    $5,0x130($0)
P 00000070 fc000000  halt
P 00000200 12345678  load data
S 00000100 0000002f
S 00000104 ffffffc5
S 00000108 00000030
S 0000010c ffffffff
S 00000110 00000001
S 00000114 00000000
S 00000118 123456ac
S 0000011c 00000035
S 00000120 fffffffa
S 00000130 00000030

/* all.f */
hw/cpu_pkg.sv
hw/mem_arbiter.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
test/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the processor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module cpu_tb --Mdir obj_dir -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/cpu_tb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
